/* avr_io_sys.f */
+incdir+src
src/avr_io_pkg.sv
src/io_decode.sv
src/tick_prescaler.sv
src/io_timer.sv
src/basic_io_regs.sv
src/irq_ctrl.sv
src/avr_io_sys.sv
sim/avr_io_sys_tb.sv

/* sim/avr_io_sys_tb.sv */
`default_nettype none

`include "avr_io_settings.svh"

module avr_io_sys_tb
    import avr_io_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [15:0] LFSR_SEED      = 16'd53267;
    localparam int          TIMEOUT_CYCLES = 4000;  // six tests of at most 300 cycles
    localparam int          TEST_COUNT     = 6;

    localparam logic [`IO_ADDR_W-1:0] A_SW_LO  = `BASIC_BASE + 6'd0;
    localparam logic [`IO_ADDR_W-1:0] A_SW_HI  = `BASIC_BASE + 6'd1;
    localparam logic [`IO_ADDR_W-1:0] A_LED_LO = `BASIC_BASE + 6'd4;
    localparam logic [`IO_ADDR_W-1:0] A_LED_HI = `BASIC_BASE + 6'd5;
    localparam logic [`IO_ADDR_W-1:0] A_CTRL   = `TIMER_BASE + 6'd0;
    localparam logic [`IO_ADDR_W-1:0] A_CMP    = `TIMER_BASE + 6'd1;
    localparam logic [`IO_ADDR_W-1:0] A_COUNT  = `TIMER_BASE + 6'd2;
    localparam logic [`IO_ADDR_W-1:0] A_STATE  = `TIMER_BASE + 6'd3;
    localparam logic [`IO_ADDR_W-1:0] A_IRQ_EN = `IRQ_BASE + 6'd0;
    localparam logic [`IO_ADDR_W-1:0] A_PEND   = `IRQ_BASE + 6'd1;
    localparam logic [`IO_ADDR_W-1:0] A_VECT   = `IRQ_BASE + 6'd2;

    logic                clk;
    logic                rst;
    io_req_t             io_req;
    logic [7:0]          io_rdata;
    logic                ieack;
    logic [`IVECT_W-1:0] ieack_vect;
    logic                iflag;
    logic [`IVECT_W-1:0] ivect;
    logic [15:0]         sw;
    logic [4:0]          btn;
    logic [15:0]         led;

    int          cycle;
    int          errors;
    int          checks;
    int          tests_done;
    logic [15:0] lfsr_state;

    avr_io_sys i_dut (
        .clk        (clk),
        .rst        (rst),
        .io_req     (io_req),
        .io_rdata   (io_rdata),
        .ieack      (ieack),
        .ieack_vect (ieack_vect),
        .iflag      (iflag),
        .ivect      (ivect),
        .sw         (sw),
        .btn        (btn),
        .led        (led)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    // outputs come out of reset cleared
    assert property (@(posedge clk) rst |=> (!iflag && led == 16'h0000))
        else begin
            errors++;
            $display("iflag or led was not cleared by reset");
        end

    assert property (@(posedge clk) disable iff (rst)
                     i_dut.timer_event |=> !i_dut.timer_event)
        else begin
            errors++;
            $display("timer_event stayed high for more than one cycle");
        end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0])
            return (s >> 1) ^ 16'hB400;
        return s >> 1;
    endfunction

    task automatic random_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val[i] = lfsr_state[0];     // one step per bit
        end
    endtask

    function automatic logic [7:0] ctrl_byte(input logic en, input timer_mode_t mode,
                                             input logic [1:0] psel);
        return {4'b0000, psel, mode, en};
    endfunction

    // bus tasks start and end 1 ns after a rising edge
    task automatic io_write(input logic [`IO_ADDR_W-1:0] a, input logic [7:0] d);
        io_req = '0;
        io_req.we = 1'b1;
        io_req.addr = a;
        io_req.wdata = d;
        @(posedge clk);
        #1;
        io_req = '0;
    endtask

    task automatic io_read(input logic [`IO_ADDR_W-1:0] a, output logic [7:0] d);
        io_req = '0;
        io_req.re = 1'b1;
        io_req.addr = a;
        #5;
        d = io_rdata;   // well before the closing edge
        @(posedge clk);
        #1;
        io_req = '0;
    endtask

    task automatic check_val(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        checks++;
        assert (got === exp)
            else begin
                errors++;
                $display("ERROR %s: got 0x%h expected 0x%h", name, got, exp);
            end
    endtask

    task automatic check_read(input logic [`IO_ADDR_W-1:0] a, input logic [7:0] exp);
        logic [7:0] rd;
        io_read(a, rd);
        check_val($sformatf("io_rdata @0x%h", a), {8'h00, rd}, {8'h00, exp});
    endtask

    task automatic acknowledge(input logic [`IVECT_W-1:0] v);
        ieack = 1'b1;
        ieack_vect = v;
        @(posedge clk);
        #1;
        ieack = 1'b0;
        ieack_vect = '0;
    endtask

    task automatic wait_iflag(input int limit, output int at_cycle);
        int n;
        n = 0;
        while (!iflag && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        checks++;
        assert (iflag)
            else begin
                errors++;
                $display("iflag did not rise within %0d cycles", limit);
            end
        at_cycle = cycle;
    endtask

    task automatic wait_read(input logic [`IO_ADDR_W-1:0] a, input logic [7:0] exp,
                             input int limit);
        logic [7:0] rd;
        int         n;
        n = 0;
        rd = ~exp;
        while (rd !== exp && n < limit) begin
            io_read(a, rd);
            n++;
        end
        checks++;
        assert (rd === exp)
            else begin
                errors++;
                $display("register 0x%h never reached 0x%h within %0d reads", a, exp, limit);
            end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_done++;
        if (errors == err_before)
            $display("test %0d %s: pass", tests_done, name);
        else
            $display("test %0d %s: FAIL with %0d errors", tests_done, name,
                     errors - err_before);
    endtask

    initial begin
        int           t0;
        int           t1;
        int           t2;
        int           n;
        int           err0;
        logic [7:0]   rd;
        logic [15:0]  r;
        logic [15:0]  old;
        timer_state_t st;

        cycle = 0;
        errors = 0;
        checks = 0;
        tests_done = 0;
        lfsr_state = LFSR_SEED;
        rst = 1'b1;
        io_req = '0;
        ieack = 1'b0;
        ieack_vect = '0;
        sw = '0;
        btn = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        err0 = errors;
        check_val("led", led, 16'h0000);
        check_val("iflag", {15'd0, iflag}, 16'd0);
        check_read(A_IRQ_EN, 8'h00);
        check_read(A_PEND, 8'h00);
        check_read(A_STATE, {6'd0, T_IDLE});
        check_read(A_CTRL, 8'h00);
        end_test("reset values", err0);

        err0 = errors;
        for (int i = 0; i < 4; i++) begin
            random_bits(16, r);
            old = sw;
            sw = r;
            @(posedge clk);
            #1;
            check_read(A_SW_LO, old[7:0]);      // one edge later the old value
            check_read(A_SW_LO, r[7:0]);
            check_read(A_SW_HI, r[15:8]);
        end
        io_write(A_LED_LO, 8'hA5);
        io_write(A_LED_HI, 8'h3C);
        check_val("led", led, 16'h3CA5);
        check_read(A_LED_LO, 8'hA5);
        check_read(A_LED_HI, 8'h3C);
        check_read(6'h20, 8'h00);   // unmapped
        end_test("basic I/O", err0);

        err0 = errors;
        io_write(A_IRQ_EN, 8'h01);
        io_write(A_CMP, 8'd6);
        io_write(A_CTRL, ctrl_byte(1'b1, MODE_ONESHOT, 2'd0));
        t0 = cycle;
        wait_iflag(300, t1);
        check_val("iflag delay", 16'(t1 - t0), 16'd7);  // compare + 1 edges
        check_val("ivect", {14'd0, ivect}, 16'd0);
        check_read(A_PEND, 8'h01);
        io_read(A_STATE, rd);
        st = timer_state_t'(rd[1:0]);
        checks++;
        assert (rd === {6'd0, T_IDLE})
            else begin
                errors++;
                $display("ERROR timer state: got 0x%h (%s) expected 0x%h", rd, st.name(),
                         {6'd0, T_IDLE});
            end
        check_read(A_COUNT, 8'd6);
        check_read(A_CTRL, 8'h00);  // enable dropped
        io_write(A_PEND, 8'h01);
        check_val("iflag", {15'd0, iflag}, 16'd0);
        end_test("one-shot timer", err0);

        err0 = errors;
        io_write(A_CMP, 8'd3);
        io_write(A_CTRL, ctrl_byte(1'b1, MODE_PERIODIC, 2'd1));
        wait_iflag(300, t1);
        acknowledge(2'd0);
        check_val("iflag", {15'd0, iflag}, 16'd0);
        wait_iflag(300, t2);
        check_val("timer period", 16'(t2 - t1), 16'd16);    // 4 * (compare + 1)
        io_write(A_CTRL, 8'h00);
        acknowledge(2'd0);
        check_val("iflag", {15'd0, iflag}, 16'd0);
        check_read(A_STATE, {6'd0, T_IDLE});
        end_test("periodic timer", err0);

        err0 = errors;
        io_write(A_IRQ_EN, 8'h03);
        io_write(A_CMP, 8'd4);
        io_write(A_CTRL, ctrl_byte(1'b1, MODE_ONESHOT, 2'd0));
        btn = 5'b00100;
        wait_read(A_PEND, 8'h03, 50);   // timer and button both pending
        check_val("iflag", {15'd0, iflag}, 16'd1);
        check_val("ivect", {14'd0, ivect}, 16'd0);
        check_read(A_VECT, 8'h00);
        acknowledge(2'd0);
        check_val("ivect", {14'd0, ivect}, 16'd1);
        check_val("iflag", {15'd0, iflag}, 16'd1);
        acknowledge(2'd1);
        check_val("iflag", {15'd0, iflag}, 16'd0);
        btn = 5'b00000;
        end_test("priority and acknowledge", err0);

        err0 = errors;
        io_write(A_IRQ_EN, 8'h01);  // button masked
        btn = 5'b00001;
        n = 0;
        while (!i_dut.basic_io.btn_event && n < 50) begin
            @(posedge clk);
            #1;
            n++;
        end
        checks++;
        assert (i_dut.basic_io.btn_event)
            else begin
                errors++;
                $display("button press produced no event");
            end
        @(posedge clk);
        #1;
        check_val("iflag", {15'd0, iflag}, 16'd0);
        check_read(A_PEND, 8'h00);
        btn = 5'b00000;
        io_write(A_CMP, 8'd2);
        io_write(A_CTRL, ctrl_byte(1'b1, MODE_ONESHOT, 2'd0));
        wait_iflag(300, t1);
        check_read(A_PEND, 8'h01);
        io_write(A_PEND, 8'h01);    // write one to clear
        check_val("iflag", {15'd0, iflag}, 16'd0);
        check_read(A_PEND, 8'h00);
        io_write(A_IRQ_EN, 8'h04);
        random_bits(16, r);
        sw = sw ^ (r | 16'h0001);   // always a change
        wait_iflag(300, t1);
        check_val("ivect", {14'd0, ivect}, 16'd2);
        check_read(A_PEND, 8'h04);
        io_write(A_PEND, 8'h04);
        check_val("iflag", {15'd0, iflag}, 16'd0);
        end_test("masking and software clear", err0);

        $display("tests %0d of %0d, checks %0d, errors %0d", tests_done, TEST_COUNT,
                 checks, errors);
        if (errors == 0 && tests_done == TEST_COUNT)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* src/avr_io_pkg.sv */
`default_nettype none

`include "avr_io_settings.svh"

package avr_io_pkg;

    // one I/O bus access from the core
    typedef struct packed {
        logic                  re;     // read strobe
        logic                  we;     // write strobe
        logic [`IO_ADDR_W-1:0] addr;
        logic [7:0]            wdata;
    } io_req_t;

    // address regions on the I/O bus
    typedef enum logic [1:0] {
        REGION_BASIC,
        REGION_TIMER,
        REGION_IRQ,
        REGION_NONE
    } io_region_t;

    // timer sequencing
    typedef enum logic [1:0] {
        T_IDLE,
        T_RUN,
        T_MATCH
    } timer_state_t;

    // control bit 1
    typedef enum logic {
        MODE_ONESHOT,
        MODE_PERIODIC
    } timer_mode_t;

endpackage

`default_nettype wire

/* src/avr_io_settings.svh */
`ifndef AVR_IO_SETTINGS_SVH
`define AVR_IO_SETTINGS_SVH

// I/O bus register address
`define IO_ADDR_W       6

// region bases on the I/O bus
`define BASIC_BASE      6'h00   // eight registers
`define TIMER_BASE      6'h08   // four registers
`define IRQ_BASE        6'h0C   // four registers

// interrupt sources and vector width
`define IRQ_COUNT       3
`define IVECT_W         2

// timer prescale select field
`define PRESCALE_SEL_W  2

`endif

/* src/avr_io_sys.sv */
`default_nettype none

`include "avr_io_settings.svh"

module avr_io_sys
    import avr_io_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst,
    input  wire io_req_t        io_req,
    output logic [7:0]          io_rdata,
    input  wire                 ieack,
    input  wire [`IVECT_W-1:0]  ieack_vect,
    output logic                iflag,
    output logic [`IVECT_W-1:0] ivect,
    input  wire [15:0]          sw,
    input  wire [4:0]           btn,
    output logic [15:0]         led
);

    logic                       basic_sel, timer_sel, irq_sel;
    logic [7:0]                 basic_rdata, timer_rdata, irq_rdata;
    logic                       tick, timer_run, timer_event;
    logic [`PRESCALE_SEL_W-1:0] prescale_sel;
    logic                       btn_event, sw_event;

    io_decode decode (
        .addr        (io_req.addr),
        .basic_rdata (basic_rdata),
        .timer_rdata (timer_rdata),
        .irq_rdata   (irq_rdata),
        .basic_sel   (basic_sel),
        .timer_sel   (timer_sel),
        .irq_sel     (irq_sel),
        .rdata       (io_rdata)
    );

    tick_prescaler prescale (
        .clk  (clk),
        .rst  (rst),
        .run  (timer_run),
        .sel  (prescale_sel),
        .tick (tick)
    );

    io_timer timer0 (                 // regs 0x08-0x0b
        .clk          (clk),
        .rst          (rst),
        .req          (io_req),
        .sel          (timer_sel),
        .tick         (tick),
        .prescale_sel (prescale_sel),
        .run          (timer_run),
        .rdata        (timer_rdata),
        .timer_event  (timer_event)
    );

    basic_io_regs basic_io (          // regs 0x00-0x07
        .clk       (clk),
        .rst       (rst),
        .req       (io_req),
        .sel       (basic_sel),
        .sw        (sw),
        .btn       (btn),
        .led       (led),
        .rdata     (basic_rdata),
        .btn_event (btn_event),
        .sw_event  (sw_event)
    );

    // sources in priority order, timer first
    irq_ctrl irq0 (                   // regs 0x0c-0x0f
        .clk        (clk),
        .rst        (rst),
        .req        (io_req),
        .sel        (irq_sel),
        .src        ({sw_event, btn_event, timer_event}),
        .ieack      (ieack),
        .ieack_vect (ieack_vect),
        .iflag      (iflag),
        .ivect      (ivect),
        .rdata      (irq_rdata)
    );

endmodule

`default_nettype wire

/* src/basic_io_regs.sv */
`default_nettype none

module basic_io_regs
    import avr_io_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire io_req_t req,
    input  wire          sel,
    input  wire [15:0]   sw,
    input  wire [4:0]    btn,     // C, U, L, R, D
    output logic [15:0]  led,
    output logic [7:0]   rdata,
    output logic         btn_event,
    output logic         sw_event
);

    localparam logic [2:0] REG_SW_LO  = 3'd0;
    localparam logic [2:0] REG_SW_HI  = 3'd1;
    localparam logic [2:0] REG_BTN    = 3'd2;
    localparam logic [2:0] REG_LED_LO = 3'd4;
    localparam logic [2:0] REG_LED_HI = 3'd5;

    logic [15:0] sw_s1, sw_s2, sw_d;
    logic [4:0]  btn_s1, btn_s2, btn_d;
    logic        wr;

    assign wr = sel && req.we;

    // two-flop synchronizers plus one delay stage for edge detect
    always_ff @(posedge clk) begin
        if (rst) begin
            sw_s1     <= '0;
            sw_s2     <= '0;
            sw_d      <= '0;
            btn_s1    <= '0;
            btn_s2    <= '0;
            btn_d     <= '0;
            btn_event <= 1'b0;
            sw_event  <= 1'b0;
        end else begin
            sw_s1     <= sw;
            sw_s2     <= sw_s1;
            sw_d      <= sw_s2;
            btn_s1    <= btn;
            btn_s2    <= btn_s1;
            btn_d     <= btn_s2;
            btn_event <= |(btn_s2 & ~btn_d);    // any press
            sw_event  <= (sw_s2 != sw_d);       // any flip
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            led <= '0;
        else if (wr && req.addr[2:0] == REG_LED_LO)
            led[7:0] <= req.wdata;
        else if (wr && req.addr[2:0] == REG_LED_HI)
            led[15:8] <= req.wdata;
    end

    always_comb begin
        rdata = 8'h00;
        if (sel && req.re) begin
            case (req.addr[2:0])
                REG_SW_LO:  rdata = sw_s2[7:0];
                REG_SW_HI:  rdata = sw_s2[15:8];
                REG_BTN:    rdata = {3'b000, btn_s2};
                REG_LED_LO: rdata = led[7:0];
                REG_LED_HI: rdata = led[15:8];
                default:    rdata = 8'h00;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/io_decode.sv */
`default_nettype none

`include "avr_io_settings.svh"

module io_decode
    import avr_io_pkg::*;
(
    input  wire [`IO_ADDR_W-1:0] addr,
    input  wire [7:0]            basic_rdata,
    input  wire [7:0]            timer_rdata,
    input  wire [7:0]            irq_rdata,
    output logic                 basic_sel,
    output logic                 timer_sel,
    output logic                 irq_sel,
    output logic [7:0]           rdata
);

    localparam logic [`IO_ADDR_W-1:0] BASIC_A = `BASIC_BASE;
    localparam logic [`IO_ADDR_W-1:0] TIMER_A = `TIMER_BASE;
    localparam logic [`IO_ADDR_W-1:0] IRQ_A   = `IRQ_BASE;

    io_region_t region;

    always_comb begin
        if (addr[`IO_ADDR_W-1:3] == BASIC_A[`IO_ADDR_W-1:3])      // 0x00-0x07
            region = REGION_BASIC;
        else if (addr[`IO_ADDR_W-1:2] == TIMER_A[`IO_ADDR_W-1:2]) // 0x08-0x0b
            region = REGION_TIMER;
        else if (addr[`IO_ADDR_W-1:2] == IRQ_A[`IO_ADDR_W-1:2])   // 0x0c-0x0f
            region = REGION_IRQ;
        else
            region = REGION_NONE;
    end

    assign basic_sel = (region == REGION_BASIC);
    assign timer_sel = (region == REGION_TIMER);
    assign irq_sel   = (region == REGION_IRQ);

    // read data source selection
    always_comb begin
        case (region)
            REGION_BASIC: rdata = basic_rdata;
            REGION_TIMER: rdata = timer_rdata;
            REGION_IRQ:   rdata = irq_rdata;
            default:      rdata = 8'h00;  // unmapped reads zero
        endcase
    end

endmodule

`default_nettype wire

/* src/io_timer.sv */
`default_nettype none

`include "avr_io_settings.svh"

module io_timer
    import avr_io_pkg::*;
(
    input  wire                        clk,
    input  wire                        rst,
    input  wire io_req_t               req,
    input  wire                        sel,
    input  wire                        tick,
    output logic [`PRESCALE_SEL_W-1:0] prescale_sel,
    output logic                       run,
    output logic [7:0]                 rdata,
    output logic                       timer_event
);

    localparam logic [1:0] REG_CTRL  = 2'd0;
    localparam logic [1:0] REG_CMP   = 2'd1;
    localparam logic [1:0] REG_COUNT = 2'd2;
    localparam logic [1:0] REG_STATE = 2'd3;

    timer_state_t              state;
    timer_mode_t               ctrl_mode;
    logic                      ctrl_en;
    logic [`PRESCALE_SEL_W-1:0] ctrl_sel;
    logic [7:0]                compare;
    logic [7:0]                count;
    logic [7:0]                count_inc;
    logic                      skip_tick;   // reload slot still owed a tick
    logic                      ctrl_wr;

    assign ctrl_wr   = sel && req.we && (req.addr[1:0] == REG_CTRL);
    assign count_inc = count + 8'd1;

    always_ff @(posedge clk) begin
        if (sel && req.we && (req.addr[1:0] == REG_CMP))
            compare <= req.wdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= T_IDLE;
            ctrl_en   <= 1'b0;
            ctrl_mode <= MODE_ONESHOT;
            ctrl_sel  <= '0;
            count     <= '0;
            skip_tick <= 1'b0;
        end else if (ctrl_wr) begin
            ctrl_en   <= req.wdata[0];
            ctrl_mode <= timer_mode_t'(req.wdata[1]);
            ctrl_sel  <= req.wdata[2 +: `PRESCALE_SEL_W];
            skip_tick <= 1'b0;
            if (req.wdata[0]) begin
                state <= T_RUN;     // (re)start from zero
                count <= '0;
            end else begin
                state <= T_IDLE;    // stop, count kept
            end
        end else begin
            case (state)
                T_RUN: begin
                    if (tick) begin
                        if (skip_tick)
                            skip_tick <= 1'b0;
                        else if (count_inc == compare) begin
                            count <= count_inc;
                            state <= T_MATCH;
                        end else
                            count <= count_inc;
                    end
                end
                T_MATCH: begin
                    if (ctrl_mode == MODE_PERIODIC) begin
                        state <= T_RUN;
                        count <= '0;
                        // count 0 holds one full tick, period is compare+1 ticks
                        skip_tick <= !tick;
                    end else begin
                        state   <= T_IDLE;
                        ctrl_en <= 1'b0;   // one-shot done
                    end
                end
                default: ;
            endcase
        end
    end

    assign run          = (state == T_RUN) || (state == T_MATCH);
    assign prescale_sel = ctrl_sel;
    assign timer_event  = (state == T_MATCH);

    always_comb begin
        rdata = 8'h00;
        if (sel && req.re) begin
            case (req.addr[1:0])
                REG_CTRL:  rdata = 8'({ctrl_sel, ctrl_mode, ctrl_en});
                REG_CMP:   rdata = compare;
                REG_COUNT: rdata = count;
                REG_STATE: rdata = 8'(state);
                default:   rdata = 8'h00;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/irq_ctrl.sv */
`default_nettype none

`include "avr_io_settings.svh"

module irq_ctrl
    import avr_io_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst,
    input  wire io_req_t         req,
    input  wire                  sel,
    input  wire [`IRQ_COUNT-1:0] src,         // bit 0 highest priority
    input  wire                  ieack,
    input  wire [`IVECT_W-1:0]   ieack_vect,
    output logic                 iflag,
    output logic [`IVECT_W-1:0]  ivect,
    output logic [7:0]           rdata
);

    localparam int N  = `IRQ_COUNT;
    localparam int VW = `IVECT_W;

    localparam logic [1:0] REG_EN   = 2'd0;
    localparam logic [1:0] REG_PEND = 2'd1;
    localparam logic [1:0] REG_VECT = 2'd2;

    logic [N-1:0] irq_en;
    logic [N-1:0] pending;
    logic [N-1:0] active;
    logic [N-1:0] ack_bits;
    logic [N-1:0] clr_bits;
    logic         wr;

    assign wr       = sel && req.we;
    assign ack_bits = ieack ? (N'(1) << ieack_vect) : '0;
    assign clr_bits = ack_bits |
                      ((wr && req.addr[1:0] == REG_PEND) ? req.wdata[N-1:0] : '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            irq_en  <= '0;
            pending <= '0;
        end else begin
            if (wr && req.addr[1:0] == REG_EN)
                irq_en <= req.wdata[N-1:0];
            pending <= (pending & ~clr_bits) | (src & irq_en);  // set beats clear
        end
    end

    assign active = pending & irq_en;
    assign iflag  = |active;

    // lowest index wins, as in the core's encoder
    always_comb begin
        ivect = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (active[i])
                ivect = VW'(i);
        end
    end

    always_comb begin
        rdata = 8'h00;
        if (sel && req.re) begin
            case (req.addr[1:0])
                REG_EN:   rdata = 8'(irq_en);
                REG_PEND: rdata = 8'(pending);
                REG_VECT: rdata = 8'(ivect);
                default:  rdata = 8'h00;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/tick_prescaler.sv */
`default_nettype none

`include "avr_io_settings.svh"

module tick_prescaler (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       run,
    input  wire [`PRESCALE_SEL_W-1:0] sel,
    output logic                      tick
);

    logic [5:0] cnt;
    logic [5:0] mask;

    // low 2*sel bits, sel 3 gives all six
    assign mask = (6'd1 << (2 * sel)) - 6'd1;

    always_ff @(posedge clk) begin
        if (rst || !run)
            cnt <= '0;      // restart from zero when stopped
        else
            cnt <= cnt + 6'd1;
    end

    // divide by 1, 4, 16 or 64
    assign tick = run && ((cnt & mask) == 6'd0);

endmodule

`default_nettype wire
